//--- Makefile
TOP := tb_ik_step

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f project.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@! grep -q "Errors found" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module ik_step_top -f project.f

clean:
	rm -rf obj_dir sim.log

//--- ik_gain_store.sv
// G is written by software between runs, index 3 on either axis is dropped
// reads outside the matrix return zero
module ik_gain_store (
	input logic i,
	input logic i_rst_n,
	input logic i_run,
	input logic i_wr_en,
	input logic [ik_pkg::IDX_W-1:0] i_wr_row,
	input logic [ik_pkg::IDX_W-1:0] i_wr_col,
	input logic signed [ik_pkg::DATA_W-1:0] i_wr_data,
	input logic [ik_pkg::IDX_W-1:0] i_rd_row,
	input logic [ik_pkg::IDX_W-1:0] i_rd_col,
	output logic signed [ik_pkg::DATA_W-1:0] o_gain
);

	logic signed [ik_pkg::DATA_W-1:0] gain_q [ik_pkg::N_JOINTS][ik_pkg::N_JOINTS];
	logic wr_ok;

	assign wr_ok = i_wr_en && (i_wr_row < ik_pkg::N_JOINTS) && (i_wr_col < ik_pkg::N_JOINTS);

	always_ff @(posedge i or negedge i_rst_n) begin
		if (!i_rst_n) begin
			gain_q <= '{default: '0};
		end else if (wr_ok) begin
			gain_q[i_wr_row][i_wr_col] <= i_wr_data;
		end
	end

	always_comb begin
		o_gain = '0;
		if ((i_rd_row < ik_pkg::N_JOINTS) && (i_rd_col < ik_pkg::N_JOINTS)) begin
			o_gain = gain_q[i_rd_row][i_rd_col];
		end
	end

	// software should only touch the matrix between steps
	a_no_bad_wr_in_run: assert property (@(posedge i) disable iff (!i_rst_n)
		(i_run && i_wr_en) |-> (i_wr_row < ik_pkg::N_JOINTS && i_wr_col < ik_pkg::N_JOINTS));

endmodule

//--- ik_joint_update.sv
// step decoder for one DLS iteration, delta = G*e with e = target - pos
// i_joint is sampled at STEP_UPDATE, the sum wraps modulo 2^16
module ik_joint_update (
	input logic i,
	input logic i_rst_n,
	input logic i_run,
	input logic [ik_pkg::STEP_W-1:0] i_step,
	input logic signed [ik_pkg::DATA_W-1:0] i_target [ik_pkg::N_JOINTS],
	input logic signed [ik_pkg::DATA_W-1:0] i_pos [ik_pkg::N_JOINTS],
	input logic signed [ik_pkg::DATA_W-1:0] i_joint [ik_pkg::N_JOINTS],
	input logic signed [ik_pkg::DATA_W-1:0] i_gain,
	output logic [ik_pkg::IDX_W-1:0] o_rd_row,
	output logic [ik_pkg::IDX_W-1:0] o_rd_col,
	output logic signed [ik_pkg::DATA_W-1:0] o_joint [ik_pkg::N_JOINTS],
	ik_mac_if.issuer m
);

	logic signed [ik_pkg::DATA_W-1:0] err_q [ik_pkg::N_JOINTS];
	logic signed [ik_pkg::DATA_W-1:0] delta_q [ik_pkg::N_JOINTS];
	logic issue_on;
	logic [ik_pkg::IDX_W-1:0] row;
	logic [ik_pkg::IDX_W-1:0] col;

	// steps 1..9 map to (row, col) in row major order
	always_comb begin
		issue_on = 1'b0;
		row = '0;
		col = '0;
		for (int r = 0; r < ik_pkg::N_JOINTS; r++) begin
			for (int c = 0; c < ik_pkg::N_JOINTS; c++) begin
				if (i_step == ik_pkg::STEP_ISSUE_FIRST + ik_pkg::N_JOINTS * r + c) begin
					issue_on = 1'b1;
					row = ik_pkg::IDX_W'(r);
					col = ik_pkg::IDX_W'(c);
				end
			end
		end
	end

	assign o_rd_row = row;
	assign o_rd_col = col;

	assign m.mac_issue = i_run && issue_on;
	assign m.mac_clear = i_run && issue_on && (col == '0); // first column opens the row sum
	assign m.mac_a = i_gain;
	assign m.mac_b = err_q[col];

	always_ff @(posedge i) begin
		if (i_run) begin
			if (i_step == ik_pkg::STEP_W'(ik_pkg::STEP_ERR)) begin
				for (int j = 0; j < ik_pkg::N_JOINTS; j++) begin
					err_q[j] <= i_target[j] - i_pos[j];
				end
			end
			// row r sum is complete at 4+3r
			for (int r = 0; r < ik_pkg::N_JOINTS; r++) begin
				if (i_step == ik_pkg::STEP_ISSUE_FIRST + ik_pkg::N_JOINTS * (r + 1)) begin
					delta_q[r] <= m.mac_acc[ik_pkg::FRAC_W +: ik_pkg::DATA_W]; // >>> 12, truncate
				end
			end
		end
	end

	always_ff @(posedge i or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_joint <= '{default: '0};
		end else if (i_run && i_step == ik_pkg::STEP_W'(ik_pkg::STEP_UPDATE)) begin
			for (int j = 0; j < ik_pkg::N_JOINTS; j++) begin
				o_joint[j] <= i_joint[j] + delta_q[j];
			end
		end
	end

endmodule

//--- ik_mac.sv
// product registered on the issue edge, summed on the next edge
// mac_acc shows the sum that the second edge after issue stores
module ik_mac (
	input logic i,
	input logic i_rst_n,
	ik_mac_if.unit m
);

	logic signed [ik_pkg::PROD_W-1:0] prod_q;
	logic signed [ik_pkg::ACC_W-1:0] prod_ext;
	logic signed [ik_pkg::ACC_W-1:0] acc_q;
	logic issue_q;
	logic clear_q;

	// issue and clear ride along with the product
	always_ff @(posedge i or negedge i_rst_n) begin
		if (!i_rst_n) begin
			issue_q <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			issue_q <= m.mac_issue;
			clear_q <= m.mac_issue && m.mac_clear;
		end
	end

	always_ff @(posedge i) begin
		if (m.mac_issue) begin
			prod_q <= m.mac_a * m.mac_b; // full 32 bit signed product
		end
	end

	assign prod_ext = prod_q; // sign extend to accumulator width

	always_comb begin
		m.mac_acc = acc_q;
		if (issue_q) begin
			if (clear_q) begin
				m.mac_acc = prod_ext;
			end else begin
				m.mac_acc = acc_q + prod_ext;
			end
		end
	end

	always_ff @(posedge i or negedge i_rst_n) begin
		if (!i_rst_n) begin
			acc_q <= '0;
		end else if (issue_q) begin
			acc_q <= m.mac_acc;
		end
	end

	// issuer must never restart a sum with no operands
	a_clear_needs_issue: assert property (@(posedge i) disable iff (!i_rst_n)
		m.mac_clear |-> m.mac_issue);

endmodule

//--- ik_mac_if.sv
// shared MAC bus, no handshake, the unit takes one operand pair per cycle
// mac_acc is the running sum including the product that lands this cycle
interface ik_mac_if;

	logic mac_issue; // operands valid this cycle
	logic mac_clear; // start a new sum with this product
	logic signed [ik_pkg::DATA_W-1:0] mac_a;
	logic signed [ik_pkg::DATA_W-1:0] mac_b;
	logic signed [ik_pkg::ACC_W-1:0] mac_acc;

	// step decoder side
	modport issuer (
		output mac_issue,
		output mac_clear,
		output mac_a,
		output mac_b,
		input mac_acc
	);

	// multiply accumulate unit
	modport unit (
		input mac_issue,
		input mac_clear,
		input mac_a,
		input mac_b,
		output mac_acc
	);

endinterface

//--- ik_pkg.sv
// fixed point is signed Q4.12 throughout, the gain matrix G arrives precomputed
// schedule numbers assume one product per cycle on a single shared MAC
package ik_pkg;

	// joints and matrix size
	localparam int N_JOINTS = 3;
	localparam int IDX_W = 2; // row and column address width

	// data path widths
	localparam int DATA_W = 16;
	localparam int PROD_W = 32;
	localparam int ACC_W = 34; // headroom for three products
	localparam int FRAC_W = 12;

	// step schedule
	localparam int STEP_W = 4;
	localparam int STEP_LAST = 12;
	localparam int STEP_ERR = 0; // error vector capture
	localparam int STEP_ISSUE_FIRST = 1; // row r column c at 1+3r+c
	localparam int STEP_UPDATE = 11; // joints take joint_in + delta

	// row r delta is captured at 4+3r, one row length after its first issue

endpackage

//--- ik_step_ctrl.sv
// run enable follows i_en combinationally so step 0 lands on the first edge with i_en high
// dropping i_en mid run aborts without touching the joints
module ik_step_ctrl (
	input logic i,
	input logic i_rst_n,
	input logic i_en,
	input logic i_step_last,
	output logic o_run,
	output logic o_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DONE
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: if (i_en) state_nxt = ST_RUN;
			ST_RUN: begin
				if (!i_en) begin
					state_nxt = ST_IDLE; // abort
				end else if (i_step_last) begin
					state_nxt = ST_DONE;
				end
			end
			ST_DONE: if (!i_en) state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// idle with i_en high is already step 0
	assign o_run = i_en && (state != ST_DONE);
	assign o_done = (state == ST_DONE);

	a_done_follows_en: assert property (@(posedge i) disable iff (!i_rst_n)
		o_done |-> $past(i_en));
	// the timer only reaches its last step inside a run
	a_last_in_run: assert property (@(posedge i) disable iff (!i_rst_n)
		i_step_last |-> (state == ST_RUN));

endmodule

//--- ik_step_timer.sv
// counts 0..STEP_LAST while run is high, then sits at zero
module ik_step_timer (
	input logic i,
	input logic i_rst_n,
	input logic i_run,
	output logic [ik_pkg::STEP_W-1:0] o_step,
	output logic o_step_last
);

	assign o_step_last = (o_step == ik_pkg::STEP_W'(ik_pkg::STEP_LAST));

	always_ff @(posedge i or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_step <= '0;
		end else if (!i_run || o_step_last) begin
			o_step <= '0; // idle, abort or end of schedule
		end else begin
			o_step <= o_step + 1'b1;
		end
	end

	a_step_in_range: assert property (@(posedge i) disable iff (!i_rst_n)
		o_step <= ik_pkg::STEP_W'(ik_pkg::STEP_LAST));

endmodule

//--- ik_step_top.sv
// one damped least squares step, G written through the register port beforehand
// hold i_en high until o_done, o_joint is valid while o_done is high
module ik_step_top (
	input logic i,
	input logic i_rst_n,
	input logic i_en,
	input logic signed [ik_pkg::DATA_W-1:0] i_target [ik_pkg::N_JOINTS],
	input logic signed [ik_pkg::DATA_W-1:0] i_pos [ik_pkg::N_JOINTS],
	input logic signed [ik_pkg::DATA_W-1:0] i_joint [ik_pkg::N_JOINTS],
	input logic i_wr_en,
	input logic [ik_pkg::IDX_W-1:0] i_wr_row,
	input logic [ik_pkg::IDX_W-1:0] i_wr_col,
	input logic signed [ik_pkg::DATA_W-1:0] i_wr_data,
	output logic signed [ik_pkg::DATA_W-1:0] o_joint [ik_pkg::N_JOINTS],
	output logic o_done
);

	logic run;
	logic step_last;
	logic [ik_pkg::STEP_W-1:0] step;
	logic [ik_pkg::IDX_W-1:0] rd_row;
	logic [ik_pkg::IDX_W-1:0] rd_col;
	logic signed [ik_pkg::DATA_W-1:0] gain;

	ik_mac_if mac_bus ();

	ik_step_ctrl u_ctrl (
		.i (i),
		.i_rst_n (i_rst_n),
		.i_en (i_en),
		.i_step_last (step_last),
		.o_run (run),
		.o_done (o_done)
	);

	ik_step_timer u_timer (
		.i (i),
		.i_rst_n (i_rst_n),
		.i_run (run),
		.o_step (step),
		.o_step_last (step_last)
	);

	ik_gain_store u_gain (
		.i (i),
		.i_rst_n (i_rst_n),
		.i_run (run),
		.i_wr_en (i_wr_en),
		.i_wr_row (i_wr_row),
		.i_wr_col (i_wr_col),
		.i_wr_data (i_wr_data),
		.i_rd_row (rd_row),
		.i_rd_col (rd_col),
		.o_gain (gain)
	);

	ik_mac u_mac (
		.i (i),
		.i_rst_n (i_rst_n),
		.m (mac_bus.unit)
	);

	ik_joint_update u_update (
		.i (i),
		.i_rst_n (i_rst_n),
		.i_run (run),
		.i_step (step),
		.i_target (i_target),
		.i_pos (i_pos),
		.i_joint (i_joint),
		.i_gain (gain),
		.o_rd_row (rd_row),
		.o_rd_col (rd_col),
		.o_joint (o_joint),
		.m (mac_bus.issuer)
	);

endmodule

//--- ik_step_trace.txt
// per record, line 1: id, gains G00 G01 G02 G10 G11 G12 G20 G21 G22
// line 2: target 0..2, pos 0..2, joint 0..2, expected joint 0..2 (hex, Q4.12)
// diagonal 0.5
0001 0800 0000 0000 0000 0800 0000 0000 0000 0800
1000 2000 0800 0800 1000 0000 0100 0200 0300 0500 0A00 0700
// permutation on the same vectors, gains must be fresh
0002 0000 1000 0000 0000 0000 1000 1000 0000 0000
1000 2000 0800 0800 1000 0000 0100 0200 0300 1100 0A00 0B00
// negative errors and a negative gain
0003 1000 0800 0000 0400 1000 F800 0000 0000 1000
0000 0400 1000 0800 0C00 0400 1000 0000 F000 0400 F000 FC00
// zero first row, floor of a negative product
0004 0000 0000 0000 0300 0200 0100 0801 0000 0000
0001 0010 0100 0003 0000 0000 1234 0100 0000 1234 0111 FFFE
// joint sums that wrap modulo 2^16
0005 4000 0000 0000 0000 4000 0000 0000 0000 4000
1000 F000 0000 0000 0000 0800 5000 A000 9000 9000 6000 7000
// large sums, delta truncated to 16 bits
0006 7FFF 0000 0000 7FFF 7FFF 7FFF 8000 0000 0000
7FFF 7FFF 7FFF 0000 0000 0000 0000 0000 0000 FFF0 FFD0 0008

//--- project.f
ik_pkg.sv
ik_mac_if.sv
ik_step_ctrl.sv
ik_step_timer.sv
ik_gain_store.sv
ik_mac.sv
ik_joint_update.sv
ik_step_top.sv
tb_ik_step.sv

//--- tb_ik_step.sv
// replays ik_step_trace.txt, so run the simulation from the project root
// trace ids must count up from 1, one record per DLS step
module tb_ik_step;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_REC = 6;
	localparam int REC_W = 22; // id, 9 gains, target, pos, joint, expected
	localparam int RUN_EDGES = 13;
	localparam int DONE_TIMEOUT = 40; // cycles allowed for o_done

	logic i;
	logic i_rst_n;
	logic i_en;
	logic signed [ik_pkg::DATA_W-1:0] i_target [ik_pkg::N_JOINTS];
	logic signed [ik_pkg::DATA_W-1:0] i_pos [ik_pkg::N_JOINTS];
	logic signed [ik_pkg::DATA_W-1:0] i_joint [ik_pkg::N_JOINTS];
	logic i_wr_en;
	logic [ik_pkg::IDX_W-1:0] i_wr_row;
	logic [ik_pkg::IDX_W-1:0] i_wr_col;
	logic signed [ik_pkg::DATA_W-1:0] i_wr_data;
	logic signed [ik_pkg::DATA_W-1:0] o_joint [ik_pkg::N_JOINTS];
	logic o_done;

	logic [ik_pkg::DATA_W-1:0] trace_mem [N_REC*REC_W];
	int errors;
	int passed;
	bit timed_out;

	ik_step_top i_ik_step_top (
		.i (i),
		.i_rst_n (i_rst_n),
		.i_en (i_en),
		.i_target (i_target),
		.i_pos (i_pos),
		.i_joint (i_joint),
		.i_wr_en (i_wr_en),
		.i_wr_row (i_wr_row),
		.i_wr_col (i_wr_col),
		.i_wr_data (i_wr_data),
		.o_joint (o_joint),
		.o_done (o_done)
	);

	initial begin
		i = 1'b0;
		forever #5 i = ~i;
	end

	task automatic report_mismatch(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic print_result(input string name, input int err_before);
		if (errors == err_before) begin
			passed++;
			$display("test %s: pass", name);
		end else begin
			$display("test %s: FAIL", name);
		end
	endtask

	// nine gain writes in row major order, then the vectors
	task automatic load_record(input int base);
		for (int k = 0; k < ik_pkg::N_JOINTS * ik_pkg::N_JOINTS; k++) begin
			@(posedge i);
			i_wr_en <= 1'b1;
			i_wr_row <= ik_pkg::IDX_W'(k / ik_pkg::N_JOINTS);
			i_wr_col <= ik_pkg::IDX_W'(k % ik_pkg::N_JOINTS);
			i_wr_data <= trace_mem[base + 1 + k];
		end
		@(posedge i);
		i_wr_en <= 1'b0;
		for (int j = 0; j < ik_pkg::N_JOINTS; j++) begin
			i_target[j] <= trace_mem[base + 10 + j];
			i_pos[j] <= trace_mem[base + 13 + j];
			i_joint[j] <= trace_mem[base + 16 + j];
		end
	endtask

	// counts edges after i_en goes high, o_done sampled mid cycle
	task automatic wait_done(output int n_edges);
		bit seen;
		seen = 1'b0;
		n_edges = 0;
		while (!seen && !timed_out) begin
			@(posedge i);
			n_edges++;
			@(negedge i);
			if (o_done) begin
				seen = 1'b1;
			end else if (n_edges >= DONE_TIMEOUT) begin
				$display("Timeout: o_done did not rise within %0d cycles of i_en", DONE_TIMEOUT);
				timed_out = 1'b1;
				errors++;
			end
		end
	endtask

	task automatic check_reset();
		int err_before;
		err_before = errors;
		assert (o_done == 1'b0) else report_mismatch("o_done is high after reset");
		for (int j = 0; j < ik_pkg::N_JOINTS; j++) begin
			assert (o_joint[j] == '0)
			else report_mismatch($sformatf("o_joint[%0d] is %h after reset", j, o_joint[j]));
		end
		print_result("reset", err_before);
	endtask

	task automatic run_record(input int rec);
		int base;
		int err_before;
		int n_edges;
		logic [ik_pkg::DATA_W-1:0] id;
		logic [ik_pkg::DATA_W-1:0] exp_joint;
		logic signed [ik_pkg::DATA_W-1:0] held [ik_pkg::N_JOINTS];
		base = rec * REC_W;
		err_before = errors;
		id = trace_mem[base];
		assert (id == ik_pkg::DATA_W'(rec + 1)) else begin
			$display("Trace record %0d is missing or out of order, the trace file looks wrong", rec);
			errors++;
		end
		load_record(base);
		@(posedge i);
		i_en <= 1'b1;
		wait_done(n_edges);
		if (timed_out) begin
			$display("test %0h: timed out", id);
		end else begin
			assert (n_edges == RUN_EDGES)
			else report_mismatch($sformatf("test %0h: o_done after %0d edges, expected %0d",
				id, n_edges, RUN_EDGES));
			for (int j = 0; j < ik_pkg::N_JOINTS; j++) begin
				exp_joint = trace_mem[base + 19 + j];
				held[j] = o_joint[j];
				assert (o_joint[j] == exp_joint)
				else report_mismatch($sformatf("test %0h: o_joint[%0d] is %h, expected %h",
					id, j, o_joint[j], exp_joint));
			end
			// enable low, done must drop one edge later
			@(posedge i);
			i_en <= 1'b0;
			@(posedge i);
			@(negedge i);
			assert (o_done == 1'b0)
			else report_mismatch($sformatf("test %0h: o_done still high after i_en fell", id));
			for (int j = 0; j < ik_pkg::N_JOINTS; j++) begin
				assert (o_joint[j] == held[j])
				else report_mismatch($sformatf("test %0h: o_joint[%0d] changed to %h after done",
					id, j, o_joint[j]));
			end
			print_result($sformatf("%0h", id), err_before);
		end
	endtask

	initial begin
		errors = 0;
		passed = 0;
		timed_out = 1'b0;
		i_rst_n = 1'b0;
		i_en = 1'b0;
		i_wr_en = 1'b0;
		i_wr_row = '0;
		i_wr_col = '0;
		i_wr_data = '0;
		for (int j = 0; j < ik_pkg::N_JOINTS; j++) begin
			i_target[j] = '0;
			i_pos[j] = '0;
			i_joint[j] = '0;
		end
		$readmemh("ik_step_trace.txt", trace_mem);
		repeat (5) @(posedge i);
		i_rst_n <= 1'b1;
		@(negedge i);
		check_reset();
		// records run back to back with no reset in between
		for (int rec = 0; rec < N_REC; rec++) begin
			run_record(rec);
			if (timed_out) break;
		end
		$display("%0d tests run, %0d passed, %0d errors", N_REC + 1, passed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
